/* src/div_defs.svh */
/*
 * width and iteration count macros for the divide unit
 */
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// ==============================
// datapath widths
// ==============================
`define DIV_XLEN  64  // full operand width
`define DIV_WLEN  32  // word operand width

// ==============================
// iteration control
// ==============================
// counter must hold XLEN itself, hence 7 bits
`define DIV_CNT_W 7

`endif

/* src/div_pkg.sv */
/*
 * divide unit types: one-hot operation encoding and FSM states
 */
`default_nettype none

package div_pkg;

  // ==============================
  // operation encoding
  // ==============================
  // one bit per M-extension divide op, zero marks a stored exception result
  typedef enum logic [7:0] {
    OP_EXC   = 8'b0000_0000,  // div by zero or overflow, value precomputed
    OP_DIV   = 8'b1000_0000,  // signed, 64
    OP_DIVU  = 8'b0100_0000,  // unsigned, 64
    OP_DIVUW = 8'b0010_0000,  // unsigned, 32
    OP_DIVW  = 8'b0001_0000,  // signed, 32
    OP_REM   = 8'b0000_1000,  // signed, 64
    OP_REMU  = 8'b0000_0100,  // unsigned, 64
    OP_REMUW = 8'b0000_0010,  // unsigned, 32
    OP_REMW  = 8'b0000_0001   // signed, 32
  } div_op_e;

  // ==============================
  // control FSM
  // ==============================
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    DO_DIV = 2'b01,
    FINISH = 2'b10
  } div_state_e;

endpackage

`default_nettype wire

/* src/div_ifs.sv */
/*
 * internal buses of the divide unit: operand start bundle
 * and registered result bundle
 */
`timescale 1ns/1ps
`default_nettype none
`include "div_defs.svh"

// prepared operands, combinational from the top-level inputs
interface div_start_if import div_pkg::*; ();
  logic [`DIV_XLEN-1:0]  dividend_mag;  // word ops packed into upper half
  logic [`DIV_XLEN-1:0]  divisor_mag;
  logic [`DIV_CNT_W-1:0] iter_cnt;      // 64 or 32
  logic                  q_neg;
  logic                  r_neg;
  div_op_e               op;
  logic                  exc;           // zero divisor or signed overflow
  logic [`DIV_XLEN-1:0]  exc_value;     // architectural result for exc

  modport src (output dividend_mag, divisor_mag, iter_cnt, q_neg, r_neg, op, exc, exc_value);
  modport dst (input  dividend_mag, divisor_mag, iter_cnt, q_neg, r_neg, op, exc, exc_value);
endinterface

// raw quotient and remainder out of the iteration registers
interface div_result_if import div_pkg::*; ();
  logic [`DIV_XLEN-1:0] quot;
  logic [`DIV_XLEN-1:0] rem;
  div_op_e              op;
  logic                 q_neg;
  logic                 r_neg;

  modport src (output quot, rem, op, q_neg, r_neg);
  modport dst (input  quot, rem, op, q_neg, r_neg);
endinterface

`default_nettype wire

/* src/div_prep.sv */
/*
 * operand preparation: magnitudes, word packing, sign flags
 * and divide-by-zero / overflow detection
 */
`timescale 1ns/1ps
`default_nettype none
`include "div_defs.svh"

module div_prep import div_pkg::*; (
  input  wire logic [`DIV_XLEN-1:0] dividend_i,
  input  wire logic [`DIV_XLEN-1:0] divisor_i,
  input  wire div_op_e              div_op_i,
  div_start_if.src                  start
);

  // two's complement magnitude of a signed value
  function automatic logic [`DIV_XLEN-1:0] abs_val(input logic [`DIV_XLEN-1:0] v);
    abs_val = v[`DIV_XLEN-1] ? (~v + 1'b1) : v;
  endfunction

  // ==============================
  // operation class
  // ==============================
  logic is_word;
  logic is_signed;
  logic is_rem;

  assign is_word   = (div_op_i == OP_DIVW) || (div_op_i == OP_DIVUW) ||
                     (div_op_i == OP_REMW) || (div_op_i == OP_REMUW);
  assign is_signed = (div_op_i == OP_DIV)  || (div_op_i == OP_DIVW) ||
                     (div_op_i == OP_REM)  || (div_op_i == OP_REMW);
  assign is_rem    = (div_op_i == OP_REM)  || (div_op_i == OP_REMU) ||
                     (div_op_i == OP_REMW) || (div_op_i == OP_REMUW);

  // ==============================
  // magnitudes
  // ==============================
  logic [`DIV_XLEN-1:0] dividend_sext;   // low word, sign extended
  logic [`DIV_XLEN-1:0] divisor_sext;
  logic [`DIV_XLEN-1:0] dividend_abs64;
  logic [`DIV_XLEN-1:0] divisor_abs64;
  logic [`DIV_XLEN-1:0] dividend_abs32;
  logic [`DIV_XLEN-1:0] divisor_abs32;
  logic [`DIV_WLEN-1:0] dividend_word;   // word magnitude or raw word
  logic [`DIV_WLEN-1:0] divisor_word;
  logic                 dividend_sign;
  logic                 divisor_sign;

  assign dividend_sext  = {{`DIV_WLEN{dividend_i[`DIV_WLEN-1]}}, dividend_i[`DIV_WLEN-1:0]};
  assign divisor_sext   = {{`DIV_WLEN{divisor_i[`DIV_WLEN-1]}}, divisor_i[`DIV_WLEN-1:0]};
  assign dividend_abs64 = abs_val(dividend_i);
  assign divisor_abs64  = abs_val(divisor_i);
  assign dividend_abs32 = abs_val(dividend_sext);  // -2^31 gives 2^31, fits in 32
  assign divisor_abs32  = abs_val(divisor_sext);

  assign dividend_word = is_signed ? dividend_abs32[`DIV_WLEN-1:0]
                                   : dividend_i[`DIV_WLEN-1:0];
  assign divisor_word  = is_signed ? divisor_abs32[`DIV_WLEN-1:0]
                                   : divisor_i[`DIV_WLEN-1:0];

  assign dividend_sign = is_word ? dividend_i[`DIV_WLEN-1] : dividend_i[`DIV_XLEN-1];
  assign divisor_sign  = is_word ? divisor_i[`DIV_WLEN-1]  : divisor_i[`DIV_XLEN-1];

  // word dividend sits in the upper half so 32 shifts bring it through
  always_comb begin
    if (is_word) begin
      start.dividend_mag = {dividend_word, {`DIV_WLEN{1'b0}}};
      start.divisor_mag  = {{`DIV_WLEN{1'b0}}, divisor_word};
      start.iter_cnt     = `DIV_CNT_W'(`DIV_WLEN);
    end else begin
      start.dividend_mag = is_signed ? dividend_abs64 : dividend_i;
      start.divisor_mag  = is_signed ? divisor_abs64  : divisor_i;
      start.iter_cnt     = `DIV_CNT_W'(`DIV_XLEN);
    end
  end

  assign start.q_neg = is_signed & (dividend_sign ^ divisor_sign);
  assign start.r_neg = is_signed & dividend_sign;  // remainder follows dividend
  assign start.op    = div_op_i;

  // ==============================
  // exceptions
  // ==============================
  logic div_zero;
  logic div_ovf;

  assign div_zero = is_word ? (divisor_i[`DIV_WLEN-1:0] == '0) : (divisor_i == '0);

  // most negative / -1
  assign div_ovf = is_signed & ~div_zero &
                   (is_word ? ((dividend_i[`DIV_WLEN-1:0] == {1'b1, {(`DIV_WLEN-1){1'b0}}}) &&
                               (&divisor_i[`DIV_WLEN-1:0]))
                            : ((dividend_i == {1'b1, {(`DIV_XLEN-1){1'b0}}}) &&
                               (&divisor_i)));

  assign start.exc = div_zero | div_ovf;

  always_comb begin
    if (div_zero) begin
      if (is_rem) start.exc_value = is_word ? dividend_sext : dividend_i;
      else        start.exc_value = '1;              // quotient all ones
    end else if (div_ovf) begin
      if (is_rem) start.exc_value = '0;
      else        start.exc_value = is_word ? dividend_sext : dividend_i;
    end else begin
      start.exc_value = '0;
    end
  end

endmodule

`default_nettype wire

/* src/div_iter_core.sv */
/*
 * control FSM and restoring shift-subtract iteration,
 * one quotient bit per cycle
 */
`timescale 1ns/1ps
`default_nettype none
`include "div_defs.svh"

module div_iter_core import div_pkg::*; (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic div_valid_i,
  input  wire logic result_ready_i,
  div_start_if.dst  start,
  div_result_if.src res,
  output logic      busy_o,
  output logic      result_ok_o
);

  // ==============================
  // state
  // ==============================
  div_state_e            state;
  div_state_e            next_state;
  logic [`DIV_CNT_W-1:0] cnt;          // steps still to run
  logic                  accept;

  logic [2*`DIV_XLEN-1:0] rq;          // remainder : quotient
  logic [`DIV_XLEN-1:0]   divisor_q;
  div_op_e                op_q;
  logic                   q_neg_q;
  logic                   r_neg_q;

  assign accept = (state == IDLE) && div_valid_i;

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (div_valid_i) next_state = start.exc ? FINISH : DO_DIV;
      end
      DO_DIV: begin
        if (cnt == `DIV_CNT_W'(1)) next_state = FINISH;  // last step this cycle
      end
      FINISH: begin
        if (result_ready_i) next_state = IDLE;
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      state <= next_state;
      if (accept) begin
        cnt <= start.iter_cnt;
      end else if (state == DO_DIV) begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // ==============================
  // iteration datapath
  // ==============================
  // trial subtract on the partial remainder shifted by one
  logic [`DIV_XLEN:0] trial;

  assign trial = rq[2*`DIV_XLEN-1:`DIV_XLEN-1] - {1'b0, divisor_q};

  always_ff @(posedge clk) begin
    if (accept) begin
      if (start.exc) begin
        rq      <= {{`DIV_XLEN{1'b0}}, start.exc_value};  // parked in quotient half
        op_q    <= OP_EXC;
        q_neg_q <= 1'b0;
        r_neg_q <= 1'b0;
      end else begin
        rq      <= {{`DIV_XLEN{1'b0}}, start.dividend_mag};
        op_q    <= start.op;
        q_neg_q <= start.q_neg;
        r_neg_q <= start.r_neg;
      end
      divisor_q <= start.divisor_mag;
    end else if (state == DO_DIV) begin
      if (trial[`DIV_XLEN]) begin
        rq <= {rq[2*`DIV_XLEN-2:0], 1'b0};  // borrow, restore
      end else begin
        rq <= {trial[`DIV_XLEN-1:0], rq[`DIV_XLEN-2:0], 1'b1};
      end
    end
  end

  // ==============================
  // outputs
  // ==============================
  assign res.quot  = rq[`DIV_XLEN-1:0];
  assign res.rem   = rq[2*`DIV_XLEN-1:`DIV_XLEN];
  assign res.op    = op_q;
  assign res.q_neg = q_neg_q;
  assign res.r_neg = r_neg_q;

  assign busy_o      = (state == DO_DIV);
  assign result_ok_o = (state == FINISH);

endmodule

`default_nettype wire

/* src/div_result_sel.sv */
/*
 * result select: sign fix-up, quotient or remainder pick,
 * word sign extension
 */
`timescale 1ns/1ps
`default_nettype none
`include "div_defs.svh"

module div_result_sel import div_pkg::*; (
  div_result_if.dst                 res,
  output logic [`DIV_XLEN-1:0]      div_out_o
);

  logic [`DIV_XLEN-1:0] quot_fix;
  logic [`DIV_XLEN-1:0] rem_fix;

  // signs were stripped before iterating, put them back
  assign quot_fix = res.q_neg ? (~res.quot + 1'b1) : res.quot;
  assign rem_fix  = res.r_neg ? (~res.rem + 1'b1)  : res.rem;

  // ==============================
  // output mux
  // ==============================
  always_comb begin
    case (res.op)
      OP_DIV, OP_DIVU: begin
        div_out_o = quot_fix;
      end
      OP_REM, OP_REMU: begin
        div_out_o = rem_fix;
      end
      OP_DIVW, OP_DIVUW: begin
        // word quotient lands in bits 31:0
        div_out_o = {{`DIV_WLEN{quot_fix[`DIV_WLEN-1]}}, quot_fix[`DIV_WLEN-1:0]};
      end
      OP_REMW, OP_REMUW: begin
        // word remainder is rq bits 95:64
        div_out_o = {{`DIV_WLEN{rem_fix[`DIV_WLEN-1]}}, rem_fix[`DIV_WLEN-1:0]};
      end
      default: begin
        div_out_o = res.quot;  // OP_EXC, value already final
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/div_unit.sv */
/*
 * integer divide unit top: preparation, iteration core, result select
 */
`timescale 1ns/1ps
`default_nettype none
`include "div_defs.svh"

module div_unit import div_pkg::*; (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 div_valid_i,     // start strobe
  input  wire logic [7:0]           div_op_i,        // one-hot op
  input  wire logic [`DIV_XLEN-1:0] dividend_i,
  input  wire logic [`DIV_XLEN-1:0] divisor_i,
  input  wire logic                 result_ready_i,  // consumer takes result
  output logic [`DIV_XLEN-1:0]      div_out_o,
  output logic                      busy_o,
  output logic                      result_ok_o
);

  div_start_if  start_bus ();
  div_result_if res_bus ();

  div_prep u_prep (
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .div_op_i   (div_op_e'(div_op_i)),
    .start      (start_bus.src)
  );

  div_iter_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .result_ready_i (result_ready_i),
    .start          (start_bus.dst),
    .res            (res_bus.src),
    .busy_o         (busy_o),
    .result_ok_o    (result_ok_o)
  );

  div_result_sel u_sel (
    .res       (res_bus.dst),
    .div_out_o (div_out_o)
  );

endmodule

`default_nettype wire

/* test/div_unit_properties.sv */
/*
 * concurrent assertions on the divide unit top-level handshake,
 * attached to div_unit by bind
 */
`timescale 1ns/1ps
`default_nettype none
`include "div_defs.svh"

module div_unit_properties (
  input wire logic                 clk,
  input wire logic                 rst_n,
  input wire logic                 result_ready_i,
  input wire logic [`DIV_XLEN-1:0] div_out_o,
  input wire logic                 busy_o,
  input wire logic                 result_ok_o
);

  // busy and done come from distinct FSM states
  assert property (@(posedge clk) disable iff (rst_n) !(result_ok_o && busy_o))
    else $error("busy_o and result_ok_o high together");

  // result must not move while the consumer stalls
  assert property (@(posedge clk) disable iff (rst_n)
                   (result_ok_o && !result_ready_i) |=> $stable(div_out_o))
    else $error("div_out_o changed while waiting for result_ready_i");

  assert property (@(posedge clk) disable iff (rst_n)
                   $fell(result_ok_o) |-> $past(result_ready_i))
    else $error("result_ok_o dropped without result_ready_i");

  assert property (@(posedge clk) rst_n |=> (!result_ok_o && !busy_o))
    else $error("outputs not cleared by reset");

endmodule

bind div_unit div_unit_properties u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .result_ready_i (result_ready_i),
  .div_out_o      (div_out_o),
  .busy_o         (busy_o),
  .result_ok_o    (result_ok_o)
);

`default_nettype wire

/* test/div_unit_tb.sv */
/*
 * divide unit testbench: clock and reset, random operands with corner values,
 * RISC-V reference model, latency and back-pressure checks, watchdog
 */
`timescale 1ns/1ps
`default_nettype none
`include "div_defs.svh"

module div_unit_tb import div_pkg::*; ();

  localparam int NUM_DIRECTED = 8;
  localparam int NUM_RAND     = 300;
  localparam int NUM_OPS      = NUM_DIRECTED + NUM_RAND;
  localparam logic [63:0] MIN64 = 64'h8000_0000_0000_0000;

  logic        clk;
  logic        rst_n;
  logic        valid;
  logic [7:0]  op;
  logic [63:0] dividend;
  logic [63:0] divisor;
  logic        ready;
  logic [63:0] div_out;
  logic        busy;
  logic        result_ok;

  integer seed;
  int     errors;
  int     checks;
  string  cur_name;  // op under test, for error lines
  div_op_e ops [8] = '{OP_DIV, OP_DIVU, OP_DIVUW, OP_DIVW, OP_REM, OP_REMU, OP_REMUW, OP_REMW};

  div_unit dut_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (valid),
    .div_op_i       (op),
    .dividend_i     (dividend),
    .divisor_i      (divisor),
    .result_ready_i (ready),
    .div_out_o      (div_out),
    .busy_o         (busy),
    .result_ok_o    (result_ok)
  );

  always #5 clk = ~clk;

  // ==============================
  // reference model
  // ==============================
  function automatic logic [63:0] ref_result(input div_op_e o, input logic [63:0] a, b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] sq;    // signed quotient and remainder
    logic signed [63:0] sr;
    logic signed [31:0] sa32;
    logic signed [31:0] sb32;
    logic signed [31:0] sq32;
    logic signed [31:0] sr32;
    logic               ovf64;
    logic               ovf32;
    logic [31:0]        w;
    logic [63:0]        r;
    sa    = a;
    sb    = b;
    sa32  = a[31:0];
    sb32  = b[31:0];
    ovf64 = (a == MIN64) && (b == '1);
    ovf32 = (sa32 == 32'sh8000_0000) && (sb32 == -1);
    sq    = '0;
    sr    = '0;
    sq32  = '0;
    sr32  = '0;
    // signed results kept apart so the division stays signed
    if (sb != 0 && !ovf64) begin
      sq = sa / sb;
      sr = sa % sb;
    end
    if (sb32 != 0 && !ovf32) begin
      sq32 = sa32 / sb32;
      sr32 = sa32 % sb32;
    end
    w = '0;
    r = '0;
    case (o)
      OP_DIV:   r = (b == 0) ? '1 : (ovf64 ? a : sq);
      OP_DIVU:  r = (b == 0) ? '1 : a / b;
      OP_REM:   r = (b == 0) ? a : (ovf64 ? '0 : sr);
      OP_REMU:  r = (b == 0) ? a : a % b;
      OP_DIVW:  w = (sb32 == 0) ? '1 : (ovf32 ? a[31:0] : sq32);
      OP_DIVUW: w = (b[31:0] == 0) ? '1 : a[31:0] / b[31:0];
      OP_REMW:  w = (sb32 == 0) ? a[31:0] : (ovf32 ? '0 : sr32);
      OP_REMUW: w = (b[31:0] == 0) ? a[31:0] : a[31:0] % b[31:0];
      default:  r = '0;
    endcase
    if (o == OP_DIVW || o == OP_DIVUW || o == OP_REMW || o == OP_REMUW)
      r = {{32{w[31]}}, w};  // word results sign extended
    return r;
  endfunction

  // cycles from accept to result_ok
  function automatic int exp_latency(input div_op_e o, input logic [63:0] a, b);
    logic word;
    logic sgn;
    logic zero;
    logic ovf;
    word = (o == OP_DIVW || o == OP_DIVUW || o == OP_REMW || o == OP_REMUW);
    sgn  = (o == OP_DIV || o == OP_DIVW || o == OP_REM || o == OP_REMW);
    zero = word ? (b[31:0] == 0) : (b == 0);
    ovf  = sgn && (word ? (a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff)
                        : (a == MIN64 && b == '1));
    if (zero || ovf) return 1;
    return word ? 33 : 65;
  endfunction

  // random operand, often a corner value
  function automatic logic [63:0] pick_operand();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    case ($unsigned($random(seed)) % 12)
      0:       return '0;
      1:       return '1;
      2:       return MIN64;
      3:       return {r[63:32], 32'h8000_0000};  // word most negative, junk above
      4:       return {r[63:32], 32'hffff_ffff};  // word -1
      5:       return {60'd0, r[3:0]};
      6:       return -({60'd0, r[3:0]} + 64'd1);
      default: return r;
    endcase
  endfunction

  task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR @%0t: %s %s got %h expected %h", $time, cur_name, what, got, exp);
    end
  endtask

  // ==============================
  // one operation, start to accept
  // ==============================
  task automatic run_op(input div_op_e o, input logic [63:0] a, b);
    logic [63:0] exp;
    int          lat;
    int          cycles;
    int          hold;
    logic        poke;
    exp      = ref_result(o, a, b);
    lat      = exp_latency(o, a, b);
    cur_name = o.name();
    @(posedge clk);
    valid    <= 1'b1;
    op       <= o;
    dividend <= a;
    divisor  <= b;
    cycles   = 0;
    while (cycles < 80) begin
      @(posedge clk);
      poke = (($random(seed) & 3) == 0);  // strobe while busy, must be ignored
      valid <= poke;
      if (poke) begin
        op       <= ops[$unsigned($random(seed)) % 8];
        dividend <= pick_operand();
        divisor  <= pick_operand();
      end
      @(negedge clk);
      cycles++;
      if (result_ok) break;
      check_val("busy", busy, 1'b1);
    end
    if (!result_ok) begin
      errors++;
      $display("result_ok never rose for %s", cur_name);
      return;
    end
    check_val("latency", cycles, lat);
    check_val("result", div_out, exp);
    hold = $unsigned($random(seed)) % 3;
    repeat (hold) begin
      @(posedge clk);
      valid <= 1'b0;
      @(negedge clk);
      check_val("result_ok held", result_ok, 1'b1);
      check_val("result held", div_out, exp);
    end
    @(posedge clk);
    valid <= 1'b0;
    ready <= 1'b1;
    @(posedge clk);
    ready <= 1'b0;
    @(negedge clk);
    check_val("result_ok after accept", result_ok, 1'b0);
  endtask

  // ==============================
  // main sequence
  // ==============================
  initial begin
    seed     = 32'h0b50_1168;
    errors   = 0;
    checks   = 0;
    clk      = 1'b0;
    rst_n    = 1'b1;
    valid    = 1'b0;
    op       = OP_DIV;
    dividend = '0;
    divisor  = '0;
    ready    = 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b0;

    // overflow and divide by zero first
    run_op(OP_DIV,   MIN64, '1);
    run_op(OP_REM,   MIN64, '1);
    run_op(OP_DIVW,  64'h1234_5678_8000_0000, 64'h0bad_0000_ffff_ffff);
    run_op(OP_REMW,  64'h1234_5678_8000_0000, 64'h0bad_0000_ffff_ffff);
    run_op(OP_DIVU,  64'hdead_beef_0000_0001, '0);
    run_op(OP_REM,   64'hf000_0000_0000_0007, '0);
    run_op(OP_REMUW, 64'h0000_0001_9000_0003, 64'hffff_ffff_0000_0000);
    run_op(OP_DIVW,  64'h0000_0000_0000_0064, 64'h5555_0000_0000_0000);

    for (int i = 0; i < NUM_RAND; i++) begin
      run_op(ops[$unsigned($random(seed)) % 8], pick_operand(), pick_operand());
    end

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // worst case about 70 cycles per op
  initial begin
    #((NUM_OPS * 70 + 100) * 10);
    $display("watchdog expired, the divide unit hung");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+src
src/div_pkg.sv
src/div_ifs.sv
src/div_prep.sv
src/div_iter_core.sv
src/div_result_sel.sv
src/div_unit.sv
test/div_unit_properties.sv
test/div_unit_tb.sv
